//--- source/soc_periph_config.svh
// soc_periph configuration
// Bus widths, interrupt counts and the register address map

`ifndef SOC_PERIPH_CONFIG_SVH
`define SOC_PERIPH_CONFIG_SVH

// ------------------------------
// Wishbone port
// ------------------------------
`define PERIPH_ADR_W    12
`define PERIPH_DATA_W   32

// ------------------------------
// Interrupts
// ------------------------------
`define NUM_IRQ_SRC     8       // Source 0 is tied low
`define NUM_IRQ_TGT     2       // Machine, supervisor
`define IRQ_PRIO_W      3
`define NUM_TIMERS      2
`define NUM_EXT_IRQ     5

// ------------------------------
// Address map
// ------------------------------
`define IRQ_REGION_BASE 12'h000
`define TMR_REGION_BASE 12'h100
`define REGION_SIZE     'h100

`endif

//--- source/soc_periph_pkg.sv
// soc_periph shared types
// Register request and response structs, source id, byte-lane merge

`default_nettype none

`include "soc_periph_config.svh"

package soc_periph_pkg;

    localparam int unsigned REG_OFF_W = $clog2(`REGION_SIZE);  // Byte offset in a region
    localparam int unsigned SEL_W     = `PERIPH_DATA_W / 8;
    localparam int unsigned IRQ_ID_W  = $clog2(`NUM_IRQ_SRC);

    typedef logic [IRQ_ID_W-1:0] irq_id_t;  // 0 is no source

    // Register access from the bus port to one unit
    typedef struct packed {
        logic                      valid;  // Accept cycle only
        logic                      we;
        logic [REG_OFF_W-1:0]      offset;
        logic [`PERIPH_DATA_W-1:0] wdata;
        logic [SEL_W-1:0]          sel;
    } reg_req_t;

    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] rdata;
    } reg_rsp_t;

    // Merge write data into a register by byte lane
    function automatic logic [`PERIPH_DATA_W-1:0] apply_sel(
        input logic [`PERIPH_DATA_W-1:0] old_val,
        input logic [`PERIPH_DATA_W-1:0] wdata,
        input logic [SEL_W-1:0]          sel
    );
        logic [`PERIPH_DATA_W-1:0] res;
        res = old_val;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- source/wb_slave_port.sv
// Wishbone classic slave port
// Decodes the controller and timer regions, one fixed wait state,
// err for unmapped addresses

`default_nettype none

`include "soc_periph_config.svh"

module wb_slave_port
    import soc_periph_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [`PERIPH_ADR_W-1:0]  wb_adr_i,
    input  logic [`PERIPH_DATA_W-1:0] wb_dat_i,
    input  logic [SEL_W-1:0]          wb_sel_i,
    output reg_req_t                  tmr_req_o,
    output reg_req_t                  irq_req_o,
    input  reg_rsp_t                  tmr_rsp_i,
    input  reg_rsp_t                  irq_rsp_i,
    output logic [`PERIPH_DATA_W-1:0] wb_dat_o,
    output logic                      wb_ack_o,
    output logic                      wb_err_o
);
    localparam int unsigned ADR_W = `PERIPH_ADR_W;
    localparam logic [ADR_W-1:0] IRQ_BASE = `IRQ_REGION_BASE;
    localparam logic [ADR_W-1:0] TMR_BASE = `TMR_REGION_BASE;

    logic     accept;
    logic     hit_irq;
    logic     hit_tmr;
    reg_req_t base_req;

    // New access only while no response is out
    assign accept  = wb_cyc_i && wb_stb_i && !(wb_ack_o || wb_err_o);
    assign hit_irq = (wb_adr_i[ADR_W-1:REG_OFF_W] == IRQ_BASE[ADR_W-1:REG_OFF_W]);
    assign hit_tmr = (wb_adr_i[ADR_W-1:REG_OFF_W] == TMR_BASE[ADR_W-1:REG_OFF_W]);

    always_comb begin
        base_req.valid  = 1'b0;
        base_req.we     = wb_we_i;
        base_req.offset = wb_adr_i[REG_OFF_W-1:0];
        base_req.wdata  = wb_dat_i;
        base_req.sel    = wb_sel_i;

        irq_req_o       = base_req;
        irq_req_o.valid = accept && hit_irq;
        tmr_req_o       = base_req;
        tmr_req_o.valid = accept && hit_tmr;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
        end else begin
            wb_ack_o <= accept && (hit_irq || hit_tmr);
            wb_err_o <= accept && !(hit_irq || hit_tmr);
        end
    end

    // Read data sampled with the write edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_dat_o <= '0;
        end else if (accept) begin
            if (hit_irq)      wb_dat_o <= irq_rsp_i.rdata;
            else if (hit_tmr) wb_dat_o <= tmr_rsp_i.rdata;
            else              wb_dat_o <= '0;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(wb_ack_o && wb_err_o));

endmodule

`default_nettype wire

//--- source/timer_unit.sv
// Two compare timers
// Count, compare and control per timer, sticky status drives a level irq

`default_nettype none

`include "soc_periph_config.svh"

module timer_unit
    import soc_periph_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  reg_req_t               req_i,
    output reg_rsp_t               rsp_o,
    output logic [`NUM_TIMERS-1:0] irq_o
);
    localparam int unsigned NT = `NUM_TIMERS;
    localparam int unsigned DW = `PERIPH_DATA_W;

    localparam logic [1:0] REG_COUNT = 2'd0;  // +0x0
    localparam logic [1:0] REG_CMP   = 2'd1;  // +0x4
    localparam logic [1:0] REG_CTRL  = 2'd2;  // +0x8

    logic [NT-1:0][DW-1:0] count_q;
    logic [NT-1:0][DW-1:0] cmp_q;
    logic [NT-1:0]         en_q;
    logic [NT-1:0]         stat_q;

    logic [3:0] tmr_idx;
    logic [1:0] reg_idx;
    logic       wr_en;

    assign tmr_idx = req_i.offset[7:4];  // 0x10 stride
    assign reg_idx = req_i.offset[3:2];
    assign wr_en   = req_i.valid && req_i.we;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
            cmp_q   <= '0;
            en_q    <= '0;
            stat_q  <= '0;
        end else begin
            for (int t = 0; t < NT; t++) begin
                if (en_q[t]) begin
                    if (count_q[t] == cmp_q[t]) begin
                        count_q[t] <= '0;
                        stat_q[t]  <= 1'b1;
                    end else begin
                        count_q[t] <= count_q[t] + 1'b1;
                    end
                end
                // Bus write wins over the count update
                if (wr_en && (tmr_idx == 4'(t))) begin
                    case (reg_idx)
                        REG_COUNT: count_q[t] <= apply_sel(count_q[t], req_i.wdata, req_i.sel);
                        REG_CMP:   cmp_q[t]   <= apply_sel(cmp_q[t], req_i.wdata, req_i.sel);
                        REG_CTRL: begin
                            if (req_i.sel[0]) begin
                                en_q[t] <= req_i.wdata[0];
                                if (req_i.wdata[1]) stat_q[t] <= 1'b0;  // W1C
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        rsp_o.rdata = '0;
        for (int t = 0; t < NT; t++) begin
            if (tmr_idx == 4'(t)) begin
                case (reg_idx)
                    REG_COUNT: rsp_o.rdata = count_q[t];
                    REG_CMP:   rsp_o.rdata = cmp_q[t];
                    REG_CTRL:  rsp_o.rdata[1:0] = {stat_q[t], en_q[t]};
                    default:   rsp_o.rdata = '0;
                endcase
            end
        end
    end

    assign irq_o = stat_q;

    for (genvar t = 0; t < NT; t++) begin : gen_chk
        a_stat_needs_en: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            $rose(stat_q[t]) |-> $past(en_q[t]));
    end

endmodule

`default_nettype wire

//--- source/irq_gateway.sv
// Level interrupt gateway
// Pending and in-service state per source, driven by claim and complete

`default_nettype none

`include "soc_periph_config.svh"

module irq_gateway
    import soc_periph_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic [`NUM_IRQ_SRC-1:0] src_i,
    input  logic                    claim_valid_i,
    input  irq_id_t                 claim_id_i,
    input  logic                    complete_valid_i,
    input  irq_id_t                 complete_id_i,
    output logic [`NUM_IRQ_SRC-1:0] pending_o
);
    logic [`NUM_IRQ_SRC-1:0] pend_q, pend_d;
    logic [`NUM_IRQ_SRC-1:0] act_q, act_d;   // In service

    always_comb begin
        // Gateway stays closed while pending or in service
        pend_d = pend_q | (src_i & ~pend_q & ~act_q);
        act_d  = act_q;
        if (claim_valid_i) begin
            pend_d[claim_id_i] = 1'b0;
            act_d[claim_id_i]  = 1'b1;
        end
        if (complete_valid_i) begin
            act_d[complete_id_i] = 1'b0;
        end
        pend_d[0] = 1'b0;  // No source 0
        act_d[0]  = 1'b0;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= '0;
            act_q  <= '0;
        end else begin
            pend_q <= pend_d;
            act_q  <= act_d;
        end
    end

    assign pending_o = pend_q;

    // Claims come from the target logic
    a_claim_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        claim_valid_i |-> pend_q[claim_id_i]);

endmodule

`default_nettype wire

//--- source/irq_target.sv
// Interrupt target logic
// Priority, enable and threshold registers, per-target arbitration,
// claim/complete register and the target interrupt lines

`default_nettype none

`include "soc_periph_config.svh"

module irq_target
    import soc_periph_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  reg_req_t                req_i,
    output reg_rsp_t                rsp_o,
    input  logic [`NUM_IRQ_SRC-1:0] pending_i,
    output logic                    claim_valid_o,
    output irq_id_t                 claim_id_o,
    output logic                    complete_valid_o,
    output irq_id_t                 complete_id_o,
    output logic [`NUM_IRQ_TGT-1:0] irq_o
);
    localparam int unsigned NSRC   = `NUM_IRQ_SRC;
    localparam int unsigned NTGT   = `NUM_IRQ_TGT;
    localparam int unsigned PRIO_W = `IRQ_PRIO_W;
    localparam int unsigned WORD_W = REG_OFF_W - 2;

    // ------------------------------
    // Word indices in the region
    // ------------------------------
    localparam int unsigned PEND_WORD  = 8;   // 0x20
    localparam int unsigned EN_WORD    = 16;  // 0x40
    localparam int unsigned THR_WORD   = 24;  // 0x60
    localparam int unsigned CLAIM_WORD = 28;  // 0x70

    logic [NSRC-1:0][PRIO_W-1:0] prio_q;      // Entry 0 never written
    logic [NTGT-1:0][NSRC-1:0]   en_q;
    logic [NTGT-1:0][PRIO_W-1:0] thr_q;

    irq_id_t [NTGT-1:0]          sel_id;
    logic [NTGT-1:0][PRIO_W-1:0] sel_prio;
    logic [WORD_W-1:0]           word;
    logic                        wr_en;

    assign word  = req_i.offset[REG_OFF_W-1:2];
    assign wr_en = req_i.valid && req_i.we && req_i.sel[0];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q <= '0;
            en_q   <= '0;
            thr_q  <= '0;
        end else if (wr_en) begin
            for (int s = 1; s < NSRC; s++) begin
                if (word == WORD_W'(s)) prio_q[s] <= req_i.wdata[PRIO_W-1:0];
            end
            for (int t = 0; t < NTGT; t++) begin
                if (word == WORD_W'(EN_WORD + t))  en_q[t]  <= req_i.wdata[NSRC-1:0];
                if (word == WORD_W'(THR_WORD + t)) thr_q[t] <= req_i.wdata[PRIO_W-1:0];
            end
        end
    end

    // Strictly above threshold, lowest id on a tie
    always_comb begin
        for (int t = 0; t < NTGT; t++) begin
            sel_id[t]   = '0;
            sel_prio[t] = thr_q[t];
            for (int s = 1; s < NSRC; s++) begin
                if (pending_i[s] && en_q[t][s] && (prio_q[s] > sel_prio[t])) begin
                    sel_id[t]   = irq_id_t'(s);
                    sel_prio[t] = prio_q[s];
                end
            end
            irq_o[t] = (sel_id[t] != '0);
        end
    end

    always_comb begin
        rsp_o.rdata = '0;
        if (word < WORD_W'(NSRC)) begin
            rsp_o.rdata[PRIO_W-1:0] = prio_q[word[IRQ_ID_W-1:0]];
        end
        if (word == WORD_W'(PEND_WORD)) rsp_o.rdata[NSRC-1:0] = pending_i;
        for (int t = 0; t < NTGT; t++) begin
            if (word == WORD_W'(EN_WORD + t))    rsp_o.rdata[NSRC-1:0]     = en_q[t];
            if (word == WORD_W'(THR_WORD + t))   rsp_o.rdata[PRIO_W-1:0]   = thr_q[t];
            if (word == WORD_W'(CLAIM_WORD + t)) rsp_o.rdata[IRQ_ID_W-1:0] = sel_id[t];
        end
    end

    // Claim on read, complete on write
    always_comb begin
        claim_valid_o    = 1'b0;
        claim_id_o       = '0;
        complete_valid_o = 1'b0;
        complete_id_o    = '0;
        for (int t = 0; t < NTGT; t++) begin
            if (req_i.valid && (word == WORD_W'(CLAIM_WORD + t))) begin
                if (req_i.we) begin
                    complete_valid_o = req_i.sel[0];
                    complete_id_o    = req_i.wdata[IRQ_ID_W-1:0];
                end else if (sel_id[t] != '0) begin
                    claim_valid_o = 1'b1;
                    claim_id_o    = sel_id[t];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/soc_periph_top.sv
// soc_periph top level
// Wishbone port, compare timers and the interrupt controller

`default_nettype none

`include "soc_periph_config.svh"

module soc_periph_top
    import soc_periph_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [`PERIPH_ADR_W-1:0]  wb_adr_i,
    input  logic [`PERIPH_DATA_W-1:0] wb_dat_i,
    input  logic [SEL_W-1:0]          wb_sel_i,
    output logic [`PERIPH_DATA_W-1:0] wb_dat_o,
    output logic                      wb_ack_o,
    output logic                      wb_err_o,
    input  logic [`NUM_EXT_IRQ-1:0]   ext_irq_i,
    output logic [`NUM_IRQ_TGT-1:0]   irq_o    // 0 machine, 1 supervisor
);
    reg_req_t                tmr_req, irq_req;
    reg_rsp_t                tmr_rsp, irq_rsp;
    logic [`NUM_TIMERS-1:0]  tmr_irq;
    logic [`NUM_IRQ_SRC-1:0] irq_src;
    logic [`NUM_IRQ_SRC-1:0] pending;
    logic                    claim_valid, complete_valid;
    irq_id_t                 claim_id, complete_id;

    // Source 0 tied low, timers on 1-2, external on 3-7
    assign irq_src = {ext_irq_i, tmr_irq, 1'b0};

    wb_slave_port i_wb_slave_port (
        .clk_i     ( clk_i    ),
        .arst_n_i  ( arst_n_i ),
        .wb_cyc_i  ( wb_cyc_i ),
        .wb_stb_i  ( wb_stb_i ),
        .wb_we_i   ( wb_we_i  ),
        .wb_adr_i  ( wb_adr_i ),
        .wb_dat_i  ( wb_dat_i ),
        .wb_sel_i  ( wb_sel_i ),
        .tmr_req_o ( tmr_req  ),
        .irq_req_o ( irq_req  ),
        .tmr_rsp_i ( tmr_rsp  ),
        .irq_rsp_i ( irq_rsp  ),
        .wb_dat_o  ( wb_dat_o ),
        .wb_ack_o  ( wb_ack_o ),
        .wb_err_o  ( wb_err_o )
    );

    timer_unit i_timer_unit (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .req_i    ( tmr_req  ),
        .rsp_o    ( tmr_rsp  ),
        .irq_o    ( tmr_irq  )
    );

    irq_gateway i_irq_gateway (
        .clk_i            ( clk_i          ),
        .arst_n_i         ( arst_n_i       ),
        .src_i            ( irq_src        ),
        .claim_valid_i    ( claim_valid    ),
        .claim_id_i       ( claim_id       ),
        .complete_valid_i ( complete_valid ),
        .complete_id_i    ( complete_id    ),
        .pending_o        ( pending        )
    );

    irq_target i_irq_target (
        .clk_i            ( clk_i          ),
        .arst_n_i         ( arst_n_i       ),
        .req_i            ( irq_req        ),
        .rsp_o            ( irq_rsp        ),
        .pending_i        ( pending        ),
        .claim_valid_o    ( claim_valid    ),
        .claim_id_o       ( claim_id       ),
        .complete_valid_o ( complete_valid ),
        .complete_id_o    ( complete_id    ),
        .irq_o            ( irq_o          )
    );

endmodule

`default_nettype wire

//--- testbench/tb_soc_periph.sv
// soc_periph testbench
// Table-driven Wishbone accesses, external interrupt stimulus and
// irq_o checks against the controller and timer register rules

`default_nettype none

`include "soc_periph_config.svh"

module tb_soc_periph;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF = 20;
    localparam int DRIVE_DLY = 2;
    localparam int BUS_LIMIT = 4;    // Cycles per access

    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_WAIT = 2'd2;
    localparam logic [1:0] OP_EXT  = 2'd3;

    localparam logic [31:0] PRIO_MASK = (32'd1 << `IRQ_PRIO_W) - 32'd1;
    localparam logic [31:0] EN_MASK   = (32'd1 << `NUM_IRQ_SRC) - 32'd1;

    typedef struct packed {
        logic [1:0]                op;
        logic [`PERIPH_ADR_W-1:0]  addr;
        logic [`PERIPH_DATA_W-1:0] wdata;     // Cycle count for a wait
        logic [`PERIPH_DATA_W-1:0] exp_data;
        logic                      exp_err;
        logic [`NUM_IRQ_TGT-1:0]   exp_irq;
    } row_t;

    logic                      clk_i;
    logic                      arst_n_i;
    logic                      wb_cyc_i;
    logic                      wb_stb_i;
    logic                      wb_we_i;
    logic [`PERIPH_ADR_W-1:0]  wb_adr_i;
    logic [`PERIPH_DATA_W-1:0] wb_dat_i;
    logic [3:0]                wb_sel_i;
    logic [`PERIPH_DATA_W-1:0] wb_dat_o;
    logic                      wb_ack_o;
    logic                      wb_err_o;
    logic [`NUM_EXT_IRQ-1:0]   ext_irq_i;
    logic [`NUM_IRQ_TGT-1:0]   irq_o;

    row_t   rows[$];
    logic   table_ready = 1'b0;
    integer seed        = 32'ha166;
    int     error_count = 0;
    int     pass_rows   = 0;
    int     fail_rows   = 0;

    soc_periph_top soc_periph_top_i (
        .clk_i     ( clk_i     ),
        .arst_n_i  ( arst_n_i  ),
        .wb_cyc_i  ( wb_cyc_i  ),
        .wb_stb_i  ( wb_stb_i  ),
        .wb_we_i   ( wb_we_i   ),
        .wb_adr_i  ( wb_adr_i  ),
        .wb_dat_i  ( wb_dat_i  ),
        .wb_sel_i  ( wb_sel_i  ),
        .wb_dat_o  ( wb_dat_o  ),
        .wb_ack_o  ( wb_ack_o  ),
        .wb_err_o  ( wb_err_o  ),
        .ext_irq_i ( ext_irq_i ),
        .irq_o     ( irq_o     )
    );

    always #CLK_HALF clk_i = ~clk_i;

    // ------------------------------
    // Table rows
    // ------------------------------
    function automatic void wr_row(input logic [11:0] addr, input logic [31:0] data,
                                   input logic err, input logic [1:0] irq);
        rows.push_back('{OP_WR, addr, data, 32'h0, err, irq});
    endfunction

    function automatic void rd_row(input logic [11:0] addr, input logic [31:0] exp,
                                   input logic err, input logic [1:0] irq);
        rows.push_back('{OP_RD, addr, 32'h0, exp, err, irq});
    endfunction

    function automatic void wait_row(input int n, input logic [1:0] irq);
        rows.push_back('{OP_WAIT, 12'h0, 32'(n), 32'h0, 1'b0, irq});
    endfunction

    function automatic void ext_row(input logic [`NUM_EXT_IRQ-1:0] val, input logic [1:0] irq);
        rows.push_back('{OP_EXT, 12'h0, 32'(val), 32'h0, 1'b0, irq});
    endfunction

    function automatic string op_name(input logic [1:0] op);
        case (op)
            OP_WR:   return "write";
            OP_RD:   return "read ";
            OP_WAIT: return "wait ";
            default: return "ext  ";
        endcase
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        // After reset
        rd_row(12'h020, 32'h0, 1'b0, 2'b00);
        rd_row(12'h040, 32'h0, 1'b0, 2'b00);
        rd_row(12'h044, 32'h0, 1'b0, 2'b00);
        rd_row(12'h060, 32'h0, 1'b0, 2'b00);
        rd_row(12'h064, 32'h0, 1'b0, 2'b00);
        rd_row(12'h100, 32'h0, 1'b0, 2'b00);
        rd_row(12'h110, 32'h0, 1'b0, 2'b00);
        // Read-back, masked to register widths
        rnd = $random(seed);
        wr_row(12'h004, rnd, 1'b0, 2'b00);
        rd_row(12'h004, rnd & PRIO_MASK, 1'b0, 2'b00);
        rnd = $random(seed);
        wr_row(12'h000, rnd, 1'b0, 2'b00);
        rd_row(12'h000, 32'h0, 1'b0, 2'b00);   // Source 0 has no priority
        wr_row(12'h040, 32'hffff_ffa5, 1'b0, 2'b00);
        rd_row(12'h040, 32'hffff_ffa5 & EN_MASK, 1'b0, 2'b00);
        rnd = $random(seed);
        wr_row(12'h060, rnd, 1'b0, 2'b00);
        rd_row(12'h060, rnd & PRIO_MASK, 1'b0, 2'b00);
        rnd = $random(seed);
        wr_row(12'h064, rnd, 1'b0, 2'b00);
        rd_row(12'h064, rnd & PRIO_MASK, 1'b0, 2'b00);
        wr_row(12'h104, 32'h1234_5678, 1'b0, 2'b00);
        rd_row(12'h104, 32'h1234_5678, 1'b0, 2'b00);
        // Unmapped region
        wr_row(12'h200, 32'h5a, 1'b1, 2'b00);
        rd_row(12'h200, 32'h0, 1'b1, 2'b00);
        wr_row(12'h240, 32'h0, 1'b1, 2'b00);    // Would alias enable 0
        rd_row(12'h040, 32'ha5, 1'b0, 2'b00);
        // External source 5 to target 0
        wr_row(12'h040, 32'h0, 1'b0, 2'b00);
        wr_row(12'h060, 32'h1, 1'b0, 2'b00);
        wr_row(12'h014, 32'h3, 1'b0, 2'b00);
        wr_row(12'h040, 32'h20, 1'b0, 2'b00);
        ext_row(5'b00100, 2'b01);
        rd_row(12'h020, 32'h20, 1'b0, 2'b01);
        rd_row(12'h070, 32'h5, 1'b0, 2'b00);
        rd_row(12'h070, 32'h0, 1'b0, 2'b00);    // In service
        rd_row(12'h020, 32'h0, 1'b0, 2'b00);
        wr_row(12'h070, 32'h5, 1'b0, 2'b01);    // Source still high
        rd_row(12'h020, 32'h20, 1'b0, 2'b01);
        ext_row(5'b00000, 2'b01);
        rd_row(12'h070, 32'h5, 1'b0, 2'b00);
        wr_row(12'h070, 32'h5, 1'b0, 2'b00);
        // Arbitration between sources 3 and 6
        wr_row(12'h00c, 32'h2, 1'b0, 2'b00);
        wr_row(12'h018, 32'h5, 1'b0, 2'b00);
        wr_row(12'h040, 32'h48, 1'b0, 2'b00);
        ext_row(5'b01001, 2'b01);
        rd_row(12'h020, 32'h48, 1'b0, 2'b01);
        rd_row(12'h070, 32'h6, 1'b0, 2'b01);
        wr_row(12'h070, 32'h6, 1'b0, 2'b01);
        wr_row(12'h018, 32'h2, 1'b0, 2'b01);    // Equal priorities
        rd_row(12'h070, 32'h3, 1'b0, 2'b01);
        wr_row(12'h070, 32'h3, 1'b0, 2'b01);
        wr_row(12'h060, 32'h2, 1'b0, 2'b00);    // Threshold equals both priorities
        rd_row(12'h070, 32'h0, 1'b0, 2'b00);
        ext_row(5'b00000, 2'b00);
        wr_row(12'h060, 32'h1, 1'b0, 2'b01);
        rd_row(12'h070, 32'h3, 1'b0, 2'b01);
        wr_row(12'h070, 32'h3, 1'b0, 2'b01);
        rd_row(12'h070, 32'h6, 1'b0, 2'b00);
        wr_row(12'h070, 32'h6, 1'b0, 2'b00);
        // Timer 0 on source 1
        wr_row(12'h104, 32'd10, 1'b0, 2'b00);
        wr_row(12'h004, 32'h4, 1'b0, 2'b00);
        wr_row(12'h040, 32'h2, 1'b0, 2'b00);
        wr_row(12'h108, 32'h1, 1'b0, 2'b00);
        wait_row(40, 2'b01);
        rd_row(12'h108, 32'h3, 1'b0, 2'b01);
        rd_row(12'h070, 32'h1, 1'b0, 2'b00);
        wr_row(12'h108, 32'h2, 1'b0, 2'b00);    // Disable, clear status
        rd_row(12'h108, 32'h0, 1'b0, 2'b00);
        wr_row(12'h070, 32'h1, 1'b0, 2'b00);
        wait_row(20, 2'b00);
        rd_row(12'h020, 32'h0, 1'b0, 2'b00);
    endtask

    // ------------------------------
    // Wishbone master
    // ------------------------------
    task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err, output logic ok);
        int waited;
        waited   = 0;
        ok       = 1'b0;
        err      = 1'b0;
        rdata    = '0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = data;
        wb_sel_i = 4'hf;
        while (!ok && waited < BUS_LIMIT) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            waited++;
            if (wb_ack_o || wb_err_o) begin
                ok    = 1'b1;
                err   = wb_err_o;
                rdata = wb_dat_o;
            end
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!ok) begin
            $display("Access to 0x%03h got no response from bus", adr);
            error_count++;
        end
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        logic [31:0] rdata;
        logic        got_err;
        logic        ok;
        int          errs_before;
        r           = rows[idx];
        errs_before = error_count;
        ok          = 1'b0;
        got_err     = 1'b0;
        rdata       = '0;
        case (r.op)
            OP_WR:   bus_access(1'b1, r.addr, r.wdata, rdata, got_err, ok);
            OP_RD:   bus_access(1'b0, r.addr, r.wdata, rdata, got_err, ok);
            OP_WAIT: repeat (r.wdata) begin
                @(posedge clk_i);
                #DRIVE_DLY;
            end
            default: ext_irq_i = r.wdata[`NUM_EXT_IRQ-1:0];
        endcase
        if (ok && got_err != r.exp_err) begin
            $display("Error: %0d ns row %0d: err %0b, expected %0b",
                     $time, idx, got_err, r.exp_err);
            error_count++;
        end
        if (ok && r.op == OP_RD && !r.exp_err && rdata != r.exp_data) begin
            $display("Error: %0d ns row %0d: read 0x%08h from 0x%03h, expected 0x%08h",
                     $time, idx, rdata, r.addr, r.exp_data);
            error_count++;
        end
        @(posedge clk_i);
        #DRIVE_DLY;
        if (wb_ack_o || wb_err_o) begin
            $display("Row %0d: bus response lasted more than one cycle", idx);
            error_count++;
        end
        if (irq_o != r.exp_irq) begin
            $display("Error: %0d ns row %0d: irq_o %02b, expected %02b",
                     $time, idx, irq_o, r.exp_irq);
            error_count++;
        end
        if (error_count == errs_before) pass_rows++;
        else fail_rows++;
        $display("row %2d %s 0x%03h: %s", idx, op_name(r.op), r.addr,
                 (error_count == errs_before) ? "ok" : "FAIL");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        clk_i     = 1'b0;
        arst_n_i  = 1'b0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        wb_sel_i  = '0;
        ext_irq_i = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        if (irq_o != '0 || wb_ack_o || wb_err_o) begin
            $display("Error: %0d ns outputs not idle after reset", $time);
            error_count++;
        end
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("Rows passed %0d, rows failed %0d, errors %0d", pass_rows, fail_rows, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (rows.size() * 64 + 10) @(posedge clk_i);
        $display("Watchdog expired before the table finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- soc_periph.f
+incdir+source
source/soc_periph_pkg.sv
source/wb_slave_port.sv
source/timer_unit.sv
source/irq_gateway.sv
source/irq_target.sv
source/soc_periph_top.sv
testbench/tb_soc_periph.sv

//--- Makefile
# Verilator flow for soc_periph

VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FLIST     ?= soc_periph.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timescale 1ns/1ps --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
